//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

   // native data bus dimensions
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int STRB_W = DATA_W / 8;

   // master to slave
   // nonzero wstrb marks a write
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
      logic [STRB_W-1:0] wstrb;
   } bus_req_t;

   // slave to master
   // ready is a single-cycle pulse with rdata alongside
   typedef struct packed {
      logic              ready;
      logic [DATA_W-1:0] rdata;
   } bus_resp_t;

endpackage

`default_nettype wire

//--- logic/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

   // address decode bits
   localparam int PERIPH_SEL_BIT = 15;
   localparam int RSTCTR_SEL_BIT = 4;

   // sram depth in words
   localparam int MEM_ADDR_W = 10;

   // uart bit timing in clock cycles
   localparam int UART_DIV   = 8;
   localparam int UART_DIV_W = $clog2(UART_DIV);

   // soft reset pulse
   localparam int SOFT_RST_CYCLES = 4;
   localparam int RST_CNT_W       = $clog2(SOFT_RST_CYCLES + 1);

   // uart register word offsets
   typedef enum logic [1:0] {
      TXDATA = 2'd0,
      STATUS = 2'd1,
      RXDATA = 2'd2
   } uart_reg_e;

   // shared by tx and rx engines
   typedef enum logic [1:0] {
      IDLE,
      START,
      DATA,
      STOP
   } uart_state_e;

   // reset controller register bits
   typedef enum logic [0:0] {
      BOOT     = 1'b0,
      SOFT_RST = 1'b1
   } rstctr_bit_e;

endpackage

`default_nettype wire

//--- logic/bus_splitter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_splitter
   import bus_pkg::*;
#(
   parameter int SEL_BIT = 0
)
(
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  m_req,
   output bus_resp_t m_resp,
   output bus_req_t  s0_req,
   output bus_req_t  s1_req,
   input  bus_resp_t s0_resp,
   input  bus_resp_t s1_resp
);

   logic sel;

   // address is held until ready, so sel stays valid for the response
   assign sel = m_req.addr[SEL_BIT];

   always_comb begin
      s0_req       = m_req;
      s1_req       = m_req;
      // only the addressed slave sees valid
      s0_req.valid = m_req.valid & ~sel;
      s1_req.valid = m_req.valid & sel;
   end

   assign m_resp = sel ? s1_resp : s0_resp;

   // request and select held steady until the response
   assert property (@(posedge clk) disable iff (!rst_n)
      m_req.valid && !m_resp.ready |=> m_req.valid && $stable(m_req.addr));

   // a slave that was not addressed must stay quiet
   assert property (@(posedge clk) disable iff (!rst_n)
      !(sel ? s0_resp.ready : s1_resp.ready));

endmodule

`default_nettype wire

//--- logic/int_mem.sv
`timescale 1ns/1ps
`default_nettype none

module int_mem
   import bus_pkg::*, soc_map_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  req,
   output bus_resp_t resp
);

   logic [DATA_W-1:0]     mem [2**MEM_ADDR_W];
   logic [MEM_ADDR_W-1:0] idx;
   logic                  accept;
   logic                  ready_q;
   logic [DATA_W-1:0]     rdata_q;

   // word index from the byte address
   assign idx    = req.addr[MEM_ADDR_W+1:2];
   // no second ready while the same request is still held
   assign accept = req.valid && !ready_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= accept;
      end
   end

   // read-before-write, so rdata holds the old word
   always_ff @(posedge clk) begin
      if (accept) begin
         rdata_q <= mem[idx];
         for (int b = 0; b < STRB_W; b++) begin
            if (req.wstrb[b])
               mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
         end
      end
   end

   assign resp.ready = ready_q;
   assign resp.rdata = rdata_q;

   // ready only while the request is still held
   assert property (@(posedge clk) disable iff (!rst_n)
      resp.ready |-> req.valid);

endmodule

`default_nettype wire

//--- logic/uart_core.sv
`timescale 1ns/1ps
`default_nettype none

module uart_core
   import bus_pkg::*, soc_map_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  req,
   output bus_resp_t resp,
   output logic      txd,
   input  logic      rxd,
   output logic      rts,
   input  logic      cts
);

   uart_reg_e         reg_sel;
   logic              accept, write, wr_tx, rd_rx;
   logic              ready_q;
   logic [DATA_W-1:0] rdata_q;

   uart_state_e           tx_state;
   logic [UART_DIV_W-1:0] tx_div;
   logic [2:0]            tx_cnt;
   logic [7:0]            tx_shift;
   logic                  tx_pend, tx_busy, tx_bit_end, txd_q;

   uart_state_e           rx_state;
   logic [UART_DIV_W-1:0] rx_div;
   logic [2:0]            rx_cnt;
   logic [7:0]            rx_shift, rx_byte;
   logic                  rxd_s1, rxd_s2;
   logic                  rx_valid, rx_half, rx_bit_end, rx_done;

   assign reg_sel = uart_reg_e'(req.addr[3:2]);
   assign accept  = req.valid && !ready_q;
   assign write   = |req.wstrb;
   // writes while busy are dropped
   assign wr_tx   = accept && write && reg_sel == TXDATA && !tx_busy;
   assign rd_rx   = accept && !write && reg_sel == RXDATA;

   // register interface
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
      end else begin
         ready_q <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         case (reg_sel)
            STATUS:  rdata_q <= {{(DATA_W-2){1'b0}}, rx_valid, tx_busy};
            RXDATA:  rdata_q <= {{(DATA_W-8){1'b0}}, rx_byte};
            default: rdata_q <= '0;
         endcase
      end
   end

   assign resp.ready = ready_q;
   assign resp.rdata = rdata_q;

   // transmitter
   assign tx_busy    = tx_pend || tx_state != IDLE;
   assign tx_bit_end = tx_div == UART_DIV_W'(UART_DIV - 1);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         tx_state <= IDLE;
         tx_div   <= '0;
         tx_cnt   <= '0;
         tx_pend  <= 1'b0;
         txd_q    <= 1'b1;
      end else begin
         if (wr_tx)
            tx_pend <= 1'b1;
         tx_div <= tx_bit_end ? '0 : tx_div + 1'b1;
         case (tx_state)
            IDLE: begin
               tx_div <= '0;
               // byte waits here while cts is low
               if (tx_pend && cts) begin
                  tx_pend  <= 1'b0;
                  tx_state <= START;
                  txd_q    <= 1'b0;
               end
            end
            START: if (tx_bit_end) begin
               tx_cnt   <= '0;
               tx_state <= DATA;
               txd_q    <= tx_shift[0];
            end
            DATA: if (tx_bit_end) begin
               if (tx_cnt == 3'd7) begin
                  tx_state <= STOP;
                  txd_q    <= 1'b1;
               end else begin
                  tx_cnt <= tx_cnt + 1'b1;
                  txd_q  <= tx_shift[1];
               end
            end
            STOP: if (tx_bit_end)
               tx_state <= IDLE;
         endcase
      end
   end

   // lsb first
   always_ff @(posedge clk) begin
      if (wr_tx)
         tx_shift <= req.wdata[7:0];
      else if (tx_state == DATA && tx_bit_end)
         tx_shift <= tx_shift >> 1;
   end

   assign txd = txd_q;

   // receiver
   assign rx_half    = rx_div == UART_DIV_W'(UART_DIV / 2 - 1);
   assign rx_bit_end = rx_div == UART_DIV_W'(UART_DIV - 1);
   // stop bit sampled high at its middle
   assign rx_done    = rx_state == STOP && rx_bit_end && rxd_s2;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rxd_s1   <= 1'b1;
         rxd_s2   <= 1'b1;
         rx_state <= IDLE;
         rx_div   <= '0;
         rx_cnt   <= '0;
         rx_valid <= 1'b0;
      end else begin
         rxd_s1 <= rxd;
         rxd_s2 <= rxd_s1;
         rx_div <= rx_bit_end ? '0 : rx_div + 1'b1;
         case (rx_state)
            IDLE: begin
               rx_div <= '0;
               if (!rxd_s2)
                  rx_state <= START;
            end
            // realign to mid-bit, reject glitches
            START: if (rx_half) begin
               rx_div   <= '0;
               rx_cnt   <= '0;
               rx_state <= rxd_s2 ? IDLE : DATA;
            end
            DATA: if (rx_bit_end) begin
               if (rx_cnt == 3'd7)
                  rx_state <= STOP;
               else
                  rx_cnt <= rx_cnt + 1'b1;
            end
            STOP: if (rx_bit_end)
               rx_state <= IDLE;
         endcase
         // overrun simply replaces the held byte
         if (rx_done)
            rx_valid <= 1'b1;
         else if (rd_rx)
            rx_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rx_state == DATA && rx_bit_end)
         rx_shift <= {rxd_s2, rx_shift[7:1]};
      if (rx_done)
         rx_byte <= rx_shift;
   end

   // peer may send only while nothing is held
   assign rts = !rx_valid;

   assert property (@(posedge clk) disable iff (!rst_n)
      tx_state == IDLE |-> txd);

endmodule

`default_nettype wire

//--- logic/rst_ctr.sv
`timescale 1ns/1ps
`default_nettype none

module rst_ctr
   import bus_pkg::*, soc_map_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  req,
   output bus_resp_t resp,
   output logic      soft_rst,
   output logic      boot
);

   logic                 accept, commit;
   logic                 ready_q, boot_q;
   logic [RST_CNT_W-1:0] cnt;
   logic [DATA_W-1:0]    rdata_q;

   assign accept = req.valid && !ready_q;
   // single register, writes take effect at the end of the ready cycle
   assign commit = req.valid && ready_q && |req.wstrb;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ready_q <= 1'b0;
         boot_q  <= 1'b1;
         cnt     <= '0;
      end else begin
         ready_q <= accept;
         if (cnt != '0)
            cnt <= cnt - 1'b1;
         if (commit) begin
            // boot can only be cleared
            boot_q <= boot_q & req.wdata[BOOT];
            if (req.wdata[SOFT_RST] && cnt == '0)
               cnt <= RST_CNT_W'(SOFT_RST_CYCLES);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rdata_q           <= '0;
         rdata_q[BOOT]     <= boot_q;
         rdata_q[SOFT_RST] <= soft_rst;
      end
   end

   assign soft_rst   = cnt != '0;
   assign boot       = boot_q;
   assign resp.ready = ready_q;
   assign resp.rdata = rdata_q;

   assert property (@(posedge clk) disable iff (!rst_n)
      $rose(soft_rst) |-> ##(SOFT_RST_CYCLES-1) soft_rst ##1 !soft_rst);

endmodule

`default_nettype wire

//--- logic/system.sv
`timescale 1ns/1ps
`default_nettype none

module system
   import bus_pkg::*, soc_map_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  bus_req_t  d_req,
   output bus_resp_t d_resp,
   output logic      boot,
   output logic      uart_txd,
   input  logic      uart_rxd,
   output logic      uart_rts,
   input  logic      uart_cts
);

   logic      soft_rst;
   logic      rst_int_n;
   bus_req_t  mem_req, p_req, uart_req, rst_req;
   bus_resp_t mem_resp, p_resp, uart_resp, rst_resp;

   // soft reset covers everything except the reset controller
   assign rst_int_n = rst_n & ~soft_rst;

   // memory below bit 15, peripherals above
   bus_splitter #(.SEL_BIT(PERIPH_SEL_BIT)) dbus_split (
      .clk     (clk),
      .rst_n   (rst_int_n),
      .m_req   (d_req),
      .m_resp  (d_resp),
      .s0_req  (mem_req),
      .s1_req  (p_req),
      .s0_resp (mem_resp),
      .s1_resp (p_resp)
   );

   bus_splitter #(.SEL_BIT(RSTCTR_SEL_BIT)) pbus_split (
      .clk     (clk),
      .rst_n   (rst_int_n),
      .m_req   (p_req),
      .m_resp  (p_resp),
      .s0_req  (uart_req),
      .s1_req  (rst_req),
      .s0_resp (uart_resp),
      .s1_resp (rst_resp)
   );

   int_mem int_mem0 (
      .clk   (clk),
      .rst_n (rst_int_n),
      .req   (mem_req),
      .resp  (mem_resp)
   );

   uart_core uart (
      .clk   (clk),
      .rst_n (rst_int_n),
      .req   (uart_req),
      .resp  (uart_resp),
      .txd   (uart_txd),
      .rxd   (uart_rxd),
      .rts   (uart_rts),
      .cts   (uart_cts)
   );

   rst_ctr rst_ctr0 (
      .clk      (clk),
      .rst_n    (rst_n),
      .req      (rst_req),
      .resp     (rst_resp),
      .soft_rst (soft_rst),
      .boot     (boot)
   );

endmodule

`default_nettype wire

//--- dv/system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module system_tb
   import bus_pkg::*, soc_map_pkg::*;
;

   localparam int N_WORDS = 64;
   // ~4 uart frames, a 200 cycle cts hold and ~260 bus cycles of 4 clocks, wide margin
   localparam int MAX_CYCLES = 20000;
   localparam logic [ADDR_W-1:0] PERIPH_BASE = ADDR_W'(1) << PERIPH_SEL_BIT;
   localparam logic [ADDR_W-1:0] UART_TX     = PERIPH_BASE;
   localparam logic [ADDR_W-1:0] UART_STAT   = PERIPH_BASE + ADDR_W'(4);
   localparam logic [ADDR_W-1:0] UART_RX     = PERIPH_BASE + ADDR_W'(8);
   localparam logic [ADDR_W-1:0] RSTCTR_REG  = PERIPH_BASE | (ADDR_W'(1) << RSTCTR_SEL_BIT);

   logic      clk, rst_n;
   bus_req_t  d_req;
   bus_resp_t d_resp;
   logic      boot, uart_txd, uart_rxd, uart_rts, uart_cts;
   logic      loop_en, rxd_drv;

   integer seed;
   int     cycle, errors, checks, err_mark;
   logic [DATA_W-1:0] shadow [2**MEM_ADDR_W];
   logic [DATA_W-1:0] got_q[$], exp_q[$];
   string             what_q[$];
   logic [DATA_W-1:0] cmp_got, cmp_exp;
   string             cmp_what;

   // txd looped back to rxd unless the testbench takes over the line
   assign uart_rxd = loop_en ? uart_txd : rxd_drv;

   system DUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .d_req    (d_req),
      .d_resp   (d_resp),
      .boot     (boot),
      .uart_txd (uart_txd),
      .uart_rxd (uart_rxd),
      .uart_rts (uart_rts),
      .uart_cts (uart_cts)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial begin
      cycle = 0;
      while (cycle < MAX_CYCLES) begin
         @(negedge clk);
         cycle++;
      end
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
   end

   // expected word after a strobed write
   function automatic logic [DATA_W-1:0] ref_mem_merge(input logic [DATA_W-1:0] old_word,
                                                       input logic [DATA_W-1:0] new_data,
                                                       input logic [STRB_W-1:0] strb);
      logic [DATA_W-1:0] res;
      int b;
      res = old_word;
      for (b = 0; b < STRB_W; b++) begin
         if (strb[b])
            res[8*b +: 8] = new_data[8*b +: 8];
      end
      return res;
   endfunction

   function automatic logic [ADDR_W-1:0] word_addr(input logic [MEM_ADDR_W-1:0] idx);
      return {{(ADDR_W-MEM_ADDR_W-2){1'b0}}, idx, 2'b00};
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR at %0t ns: %s", $time, msg);
      errors++;
   endtask

   task automatic bus_xfer(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                           input logic [STRB_W-1:0] wstrb, output logic [DATA_W-1:0] rdata);
      int waited;
      @(posedge clk);
      d_req <= '{valid: 1'b1, addr: addr, wdata: wdata, wstrb: wstrb};
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!d_resp.ready);
      rdata = d_resp.rdata;
      // valid sampled one edge after drive, ready the cycle after that
      if (waited != 2)
         report_error($sformatf("response from %h took %0d cycles, expected 1", addr,
                                waited - 1));
      @(posedge clk);
      d_req.valid <= 1'b0;
   endtask

   task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                            input logic [STRB_W-1:0] wstrb);
      logic [DATA_W-1:0] unused;
      bus_xfer(addr, wdata, wstrb, unused);
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata);
      bus_xfer(addr, '0, '0, rdata);
   endtask

   task automatic read_check(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] exp,
                             input string what);
      logic [DATA_W-1:0] got;
      bus_read(addr, got);
      got_q.push_back(got);
      exp_q.push_back(exp);
      what_q.push_back(what);
   endtask

   task automatic mem_write(input logic [MEM_ADDR_W-1:0] idx, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb);
      bus_write(word_addr(idx), data, strb);
      shadow[idx] = ref_mem_merge(shadow[idx], data, strb);
   endtask

   // polls STATUS until rx_valid shows up
   task automatic wait_rx_valid(input int limit);
      logic [DATA_W-1:0] st;
      int start;
      start = cycle;
      st = '0;
      while (!st[1] && cycle - start <= limit)
         bus_read(UART_STAT, st);
      if (!st[1])
         report_error($sformatf("no received byte within %0d cycles", limit));
   endtask

   // one 8N1 frame straight onto rxd, lsb first
   task automatic drive_rx_frame(input logic [7:0] data);
      logic [9:0] frame;
      int k;
      frame = {1'b1, data, 1'b0};
      @(posedge clk);
      loop_en <= 1'b0;
      for (k = 0; k < 10; k++) begin
         rxd_drv <= frame[k];
         repeat (UART_DIV) @(posedge clk);
      end
      loop_en <= 1'b1;
   endtask

   task automatic test_done(input string name);
      @(posedge clk);
      $display("test %-10s %s (%0d errors)", name, errors == err_mark ? "ok" : "failed",
               errors - err_mark);
      err_mark = errors;
   endtask

   // every read result is compared here
   always @(negedge clk) begin
      while (got_q.size() != 0) begin
         cmp_got  = got_q.pop_front();
         cmp_exp  = exp_q.pop_front();
         cmp_what = what_q.pop_front();
         checks++;
         if (cmp_got !== cmp_exp) begin
            $display("ERROR at %0t ns: %s read %h, expected %h", $time, cmp_what, cmp_got,
                     cmp_exp);
            errors++;
         end
      end
   end

   initial begin
      logic [MEM_ADDR_W-1:0] idx_list [N_WORDS];
      logic [DATA_W-1:0]     rnd, rd;
      logic [STRB_W-1:0]     strb;
      logic [7:0]            byte_v;
      logic                  txd_dropped, seen_rst;
      int                    i;
      seed     = 32'h6ed7;
      errors   = 0;
      checks   = 0;
      err_mark = 0;
      rst_n    = 1'b0;
      d_req    = '0;
      uart_cts = 1'b1;
      loop_en  = 1'b1;
      rxd_drv  = 1'b1;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1;

      // known contents first so partial writes merge into defined data
      for (i = 0; i < N_WORDS; i++) begin
         rnd = $random(seed);
         idx_list[i] = rnd[MEM_ADDR_W-1:0];
         rnd = $random(seed);
         mem_write(idx_list[i], rnd, 4'hf);
      end
      for (i = 0; i < N_WORDS; i++) begin
         rnd  = $random(seed);
         strb = rnd[11:8];
         if (strb == 4'h0)
            strb = 4'h1;
         rd  = $random(seed);
         mem_write(idx_list[rnd[5:0]], rd, strb);
      end
      for (i = 0; i < N_WORDS; i++)
         read_check(word_addr(idx_list[i]), shadow[idx_list[i]], "memory");
      test_done("memory");

      // TXDATA shares its low address bits with memory word 0
      rnd = $random(seed);
      mem_write('0, rnd, 4'hf);
      bus_write(UART_TX, ~rnd, 4'hf);
      read_check(word_addr('0), shadow[0], "memory word 0");
      wait_rx_valid(200);
      read_check(UART_RX, {24'h0, ~rnd[7:0]}, "aliased uart byte");
      test_done("decode");

      rnd    = $random(seed);
      byte_v = rnd[7:0];
      bus_write(UART_TX, {24'h0, byte_v}, 4'h1);
      read_check(UART_STAT, 32'h1, "status while sending");
      wait_rx_valid(100);
      @(negedge clk);
      if (uart_rts !== 1'b0)
         report_error("rts stayed high while a received byte was held");
      read_check(UART_RX, {24'h0, byte_v}, "loopback byte");
      read_check(UART_STAT, 32'h0, "status after rxdata read");
      @(negedge clk);
      if (uart_rts !== 1'b1)
         report_error("rts did not return high after rxdata read");
      test_done("loopback");

      @(posedge clk);
      uart_cts <= 1'b0;
      rnd    = $random(seed);
      byte_v = rnd[7:0];
      bus_write(UART_TX, {24'h0, byte_v}, 4'h1);
      txd_dropped = 1'b0;
      repeat (200) begin
         @(negedge clk);
         if (uart_txd !== 1'b1)
            txd_dropped = 1'b1;
      end
      if (txd_dropped)
         report_error("txd left idle while cts was low");
      @(posedge clk);
      uart_cts <= 1'b1;
      wait_rx_valid(200);
      read_check(UART_RX, {24'h0, byte_v}, "byte held by cts");
      test_done("flow");

      read_check(RSTCTR_REG, 32'h1, "boot flag after reset");
      @(negedge clk);
      if (boot !== 1'b1)
         report_error("boot output low after power-on reset");
      bus_write(RSTCTR_REG, 32'h0, 4'hf);
      read_check(RSTCTR_REG, 32'h0, "boot flag cleared");
      // byte from the line itself, held in the receiver
      rnd = $random(seed);
      drive_rx_frame(rnd[7:0]);
      wait_rx_valid(100);
      bus_write(RSTCTR_REG, 32'h2, 4'hf);
      // poll until the soft reset pulse is over
      seen_rst = 1'b0;
      do begin
         bus_read(RSTCTR_REG, rd);
         if (rd[1])
            seen_rst = 1'b1;
      end while (rd[1]);
      if (!seen_rst)
         report_error("soft reset pulse never showed in the control register");
      read_check(UART_STAT, 32'h0, "status after soft reset");
      read_check(RSTCTR_REG, 32'h0, "boot flag after soft reset");
      for (i = 0; i < N_WORDS; i++)
         read_check(word_addr(idx_list[i]), shadow[idx_list[i]], "memory after soft reset");
      read_check(word_addr('0), shadow[0], "memory word 0 after soft reset");
      test_done("reset");

      $display("summary: %0d reads compared, %0d errors", checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
logic/bus_pkg.sv
logic/soc_map_pkg.sv
logic/bus_splitter.sv
logic/int_mem.sv
logic/uart_core.sv
logic/rst_ctr.sv
logic/system.sv
dv/system_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and look for the fail marker in the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module system_tb -f build.f -o sim_tb \
   > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 &&
! grep -q ">>> FAIL" sim.log &&
grep -q ">>> PASS" sim.log &&
echo "simulation passed" ||
{ cat build.log sim.log 2>/dev/null; echo "simulation failed"; exit 1; }
